/* audio_cfg_pkg.sv */
// ------------------------------------------------
// Audio format constants and the stereo frame word
// Shared by the FIFO, the serializer and the register block
// ------------------------------------------------
package audio_cfg_pkg;

  localparam int unsigned SAMPLE_W       = 16;            // Bits per channel
  localparam int unsigned BCLK_PER_FRAME = 2 * SAMPLE_W;  // Bit clocks per LRCLK period

  // Left and right halves of one frame
  typedef struct packed {
    logic [SAMPLE_W-1:0] left;   // Upper half goes out first
    logic [SAMPLE_W-1:0] right;
  } frame_pair_t;

  // One stereo frame seen from the bus or from the serializer
  typedef union packed {
    logic [2*SAMPLE_W-1:0] raw;   // Word as written over AXI
    frame_pair_t           pair;  // Channel view
  } frame_u;

endpackage

/* audio_timing.sv */
// ------------------------------------------------
// Fractional-N generator of fs, BCLK and LRCLK from clk
// Exact average rates with edges within one clk of ideal
// Everything holds at zero while enable is low
// ------------------------------------------------
`timescale 1ns/1ps

module audio_timing #(
  parameter int unsigned CLK_RATE     = 24_576_000,  // Hz of clk
  parameter int unsigned AUDIO_RATE   = 48_000,      // fs
  parameter bit          I2S_STANDARD = 1'b1         // 0 left-justified, 1 standard
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         enable,
  i2s_timing_if.source timing,
  output logic         audio_clk  // fs pulse
);

  // Edge rates
  localparam int unsigned LR_EDGE_HZ   = 2 * AUDIO_RATE;  // Two LR edges per frame
  localparam int unsigned BCLK_EDGE_HZ = 2 * AUDIO_RATE * audio_cfg_pkg::BCLK_PER_FRAME;

  // BCLK edges from LR edge to load strobe
  localparam logic [1:0] LOAD_EDGES = I2S_STANDARD ? 2'd2 : 2'd1;

  localparam int unsigned ACC_WIDTH = $clog2(CLK_RATE);
  typedef logic [ACC_WIDTH:0] acc_t;  // Extra bit so the sum never wraps
  localparam acc_t LIMIT = acc_t'(CLK_RATE);

  acc_t acc_fs, acc_lr, acc_be;
  acc_t fs_sum, lr_sum, be_sum;
  logic fs_wrap, lr_wrap, be_wrap;

  logic fs_pulse_r;
  logic lrclk_r;
  logic bclk_r;
  logic lr_edge_pulse;  // Registered LR toggle
  logic b_edge_pulse;   // Registered BCLK toggle
  logic b_fall_pulse;
  logic load_pending;
  logic [1:0] edge_cnt;
  logic load_strobe_r;

  // ------------------------------------------------
  // Accumulator sums
  // ------------------------------------------------
  assign fs_sum  = acc_fs + acc_t'(AUDIO_RATE);
  assign lr_sum  = acc_lr + acc_t'(LR_EDGE_HZ);
  assign be_sum  = acc_be + acc_t'(BCLK_EDGE_HZ);
  assign fs_wrap = (fs_sum >= LIMIT);
  assign lr_wrap = (lr_sum >= LIMIT);
  assign be_wrap = (be_sum >= LIMIT);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc_fs        <= '0;
      acc_lr        <= '0;
      acc_be        <= '0;
      fs_pulse_r    <= 1'b0;
      lrclk_r       <= 1'b0;
      bclk_r        <= 1'b0;
      lr_edge_pulse <= 1'b0;
      b_edge_pulse  <= 1'b0;
      b_fall_pulse  <= 1'b0;
      load_pending  <= 1'b0;
      edge_cnt      <= '0;
      load_strobe_r <= 1'b0;
    end else if (!enable) begin  // Hold everything at zero
      acc_fs        <= '0;
      acc_lr        <= '0;
      acc_be        <= '0;
      fs_pulse_r    <= 1'b0;
      lrclk_r       <= 1'b0;
      bclk_r        <= 1'b0;
      lr_edge_pulse <= 1'b0;
      b_edge_pulse  <= 1'b0;
      b_fall_pulse  <= 1'b0;
      load_pending  <= 1'b0;
      edge_cnt      <= '0;
      load_strobe_r <= 1'b0;
    end else begin
      // fs pulse
      acc_fs     <= fs_wrap ? fs_sum - LIMIT : fs_sum;
      fs_pulse_r <= fs_wrap;

      // LRCLK toggles
      acc_lr        <= lr_wrap ? lr_sum - LIMIT : lr_sum;
      lr_edge_pulse <= lr_wrap;
      if (lr_wrap) lrclk_r <= ~lrclk_r;

      // BCLK toggles
      acc_be       <= be_wrap ? be_sum - LIMIT : be_sum;
      b_edge_pulse <= be_wrap;
      if (be_wrap) bclk_r <= ~bclk_r;

      b_fall_pulse <= b_edge_pulse && !bclk_r;  // Toggle that left bclk low

      // Load strobe counts BCLK edges after each LR edge
      load_strobe_r <= 1'b0;
      if (lr_edge_pulse) begin
        load_pending <= 1'b1;
        edge_cnt     <= '0;
      end else if (load_pending && b_edge_pulse) begin
        if (edge_cnt == LOAD_EDGES - 2'd1) begin
          load_strobe_r <= 1'b1;
          load_pending  <= 1'b0;
        end else begin
          edge_cnt <= edge_cnt + 2'd1;
        end
      end
    end
  end

  // ------------------------------------------------
  // Outputs
  // ------------------------------------------------
  assign audio_clk           = fs_pulse_r;
  assign timing.fs_pulse     = fs_pulse_r;
  assign timing.bclk         = bclk_r;
  assign timing.lrclk        = lrclk_r;
  assign timing.shift_strobe = b_fall_pulse;
  assign timing.load_strobe  = load_strobe_r;

endmodule

/* axil_pkg.sv */
// ------------------------------------------------
// AXI4-Lite widths, response codes and register map
// of the I2S transmitter control block
// ------------------------------------------------
package axil_pkg;

  localparam int unsigned ADDR_W = 4;
  localparam int unsigned DATA_W = 32;

  // Response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Register byte offsets
  localparam logic [ADDR_W-1:0] REG_CTRL   = 4'h0;
  localparam logic [ADDR_W-1:0] REG_STATUS = 4'h4;
  localparam logic [ADDR_W-1:0] REG_DATA   = 4'h8;  // Write only

  // CTRL bits
  localparam int unsigned CTRL_EN_BIT  = 0;
  localparam int unsigned CTRL_CLR_BIT = 1;  // Self clearing

  // STATUS fields
  localparam int unsigned STATUS_LEVEL_LSB    = 0;
  localparam int unsigned STATUS_LEVEL_W      = 8;
  localparam int unsigned STATUS_FULL_BIT     = 8;
  localparam int unsigned STATUS_EMPTY_BIT    = 9;
  localparam int unsigned STATUS_UNDERRUN_BIT = 10;

endpackage

/* frame_fifo.sv */
// ------------------------------------------------
// Synchronous FIFO of stereo frames with a level count
// Head frame is visible on the output before pop
// ------------------------------------------------
`timescale 1ns/1ps

module frame_fifo #(
  parameter int unsigned FIFO_DEPTH = 16  // Power of two
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        push,
  input  audio_cfg_pkg::frame_u       push_frame,
  input  logic                        pop,
  output audio_cfg_pkg::frame_u       head_frame,
  output logic [$clog2(FIFO_DEPTH):0] level,
  output logic                        full,
  output logic                        empty
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  audio_cfg_pkg::frame_u mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr, rd_ptr;  // Wrap on their own
  logic do_push, do_pop;

  assign full    = level[PTR_W];  // Only set at exactly FIFO_DEPTH
  assign empty   = (level == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_frame;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;  // Both or neither
      endcase
    end
  end

  assign head_frame = mem[rd_ptr];

endmodule

/* i2s_serializer.sv */
// ------------------------------------------------
// Loads one frame per LRCLK period and shifts it out
// MSB first on the BCLK falling-edge strobe
// ------------------------------------------------
`timescale 1ns/1ps

module i2s_serializer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  enable,
  i2s_timing_if.sink            timing,
  input  audio_cfg_pkg::frame_u head_frame,
  input  logic                  fifo_empty,
  output logic                  pop,
  output logic                  underrun,
  output logic                  sdata
);

  localparam int unsigned FRAME_W = audio_cfg_pkg::BCLK_PER_FRAME;

  logic [FRAME_W-1:0] shreg;  // Left word in the upper half
  logic               left_load;

  // lrclk low at load time marks the left word
  assign left_load = timing.load_strobe && !timing.lrclk;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      shreg    <= '0;
      pop      <= 1'b0;
      underrun <= 1'b0;
    end else begin
      pop      <= 1'b0;
      underrun <= 1'b0;
      if (!enable) begin
        shreg <= '0;
      end else if (left_load) begin
        if (fifo_empty) begin
          shreg    <= '0;  // Send silence
          underrun <= 1'b1;
        end else begin
          shreg <= {head_frame.pair.left, head_frame.pair.right};
          pop   <= 1'b1;   // FIFO advances on the next edge
        end
      end else if (timing.shift_strobe) begin
        shreg <= {shreg[FRAME_W-2:0], 1'b0};
      end
    end
  end

  assign sdata = enable && shreg[FRAME_W-1];  // One clk after the strobe

endmodule

/* i2s_timing_if.sv */
// ------------------------------------------------
// Bit clock, word select and strobes from the timing
// generator to the serializer
// ------------------------------------------------
`timescale 1ns/1ps

interface i2s_timing_if;

  logic bclk;          // I2S bit clock
  logic lrclk;         // Word select, low for left
  logic fs_pulse;      // One clk per frame
  logic shift_strobe;  // BCLK falling edge
  logic load_strobe;   // Start of a word

  // Timing generator side
  modport source (
    output bclk,
    output lrclk,
    output fs_pulse,
    output shift_strobe,
    output load_strobe
  );

  // Serializer side
  modport sink (
    input bclk,
    input lrclk,
    input fs_pulse,
    input shift_strobe,
    input load_strobe
  );

endinterface

/* i2s_tx.f */
audio_cfg_pkg.sv
axil_pkg.sv
i2s_timing_if.sv
audio_timing.sv
frame_fifo.sv
i2s_serializer.sv
i2s_tx_ctrl.sv
i2s_tx_top.sv
tb_clock_gen.sv
tb_i2s_tx.sv

/* i2s_tx_ctrl.sv */
// ------------------------------------------------
// AXI4-Lite slave with CTRL, STATUS and DATA registers
// DATA writes become FIFO pushes and underrun is sticky
// ------------------------------------------------
`timescale 1ns/1ps

module i2s_tx_ctrl #(
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  logic                          clk,
  input  logic                          reset,
  // AXI4-Lite write channels
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [axil_pkg::ADDR_W-1:0]   awaddr,
  input  logic                          wvalid,
  output logic                          wready,
  input  logic [axil_pkg::DATA_W-1:0]   wdata,
  input  logic [axil_pkg::DATA_W/8-1:0] wstrb,
  output logic                          bvalid,
  input  logic                          bready,
  output logic [1:0]                    bresp,
  // AXI4-Lite read channels
  input  logic                          arvalid,
  output logic                          arready,
  input  logic [axil_pkg::ADDR_W-1:0]   araddr,
  output logic                          rvalid,
  input  logic                          rready,
  output logic [axil_pkg::DATA_W-1:0]   rdata,
  output logic [1:0]                    rresp,
  // FIFO and serializer status
  input  logic [$clog2(FIFO_DEPTH):0]   fifo_level,
  input  logic                          fifo_full,
  input  logic                          fifo_empty,
  input  logic                          underrun,
  // Control outputs
  output logic                          push,
  output audio_cfg_pkg::frame_u         push_frame,
  output logic                          enable
);

  localparam int unsigned LVL_FIELD_W = axil_pkg::STATUS_LEVEL_W;

  logic                        write_fire;
  logic                        read_fire;
  logic                        underrun_flag;  // Sticky
  logic [LVL_FIELD_W-1:0]      level_field;
  logic [axil_pkg::DATA_W-1:0] strb_mask;
  logic [axil_pkg::DATA_W-1:0] status_word;

  assign write_fire  = awvalid && awready && wvalid && wready;
  assign read_fire   = arvalid && arready;
  assign level_field = LVL_FIELD_W'(fifo_level);

  // Byte lanes of wdata kept by wstrb
  always_comb begin
    for (int i = 0; i < axil_pkg::DATA_W / 8; i++) begin
      strb_mask[8*i +: 8] = {8{wstrb[i]}};
    end
  end

  always_comb begin
    status_word = '0;
    status_word[axil_pkg::STATUS_LEVEL_LSB +: LVL_FIELD_W] = level_field;
    status_word[axil_pkg::STATUS_FULL_BIT]     = fifo_full;
    status_word[axil_pkg::STATUS_EMPTY_BIT]    = fifo_empty;
    status_word[axil_pkg::STATUS_UNDERRUN_BIT] = underrun_flag;
  end

  // ------------------------------------------------
  // Write path
  // ------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      awready       <= 1'b0;
      wready        <= 1'b0;
      bvalid        <= 1'b0;
      bresp         <= axil_pkg::RESP_OKAY;
      push          <= 1'b0;
      enable        <= 1'b0;
      underrun_flag <= 1'b0;
    end else begin
      awready <= 1'b0;
      wready  <= 1'b0;
      push    <= 1'b0;
      // Accept AW and W together, never with a response pending
      if (awvalid && wvalid && !awready && !bvalid) begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
      if (bvalid && bready) bvalid <= 1'b0;
      if (write_fire) begin
        bvalid <= 1'b1;
        bresp  <= axil_pkg::RESP_OKAY;
        case (awaddr)
          axil_pkg::REG_CTRL: begin
            if (wstrb[0]) begin
              enable <= wdata[axil_pkg::CTRL_EN_BIT];
              if (wdata[axil_pkg::CTRL_CLR_BIT]) underrun_flag <= 1'b0;
            end
          end
          axil_pkg::REG_STATUS: bresp <= axil_pkg::RESP_OKAY;  // Read only
          axil_pkg::REG_DATA: begin
            if (fifo_full) bresp <= axil_pkg::RESP_SLVERR;  // Frame dropped
            else           push  <= 1'b1;
          end
          default: bresp <= axil_pkg::RESP_SLVERR;
        endcase
      end
      if (underrun) underrun_flag <= 1'b1;  // Set wins over clear
    end
  end

  always_ff @(posedge clk) begin
    if (write_fire) push_frame.raw <= wdata & strb_mask;
  end

  // ------------------------------------------------
  // Read path
  // ------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= 1'b0;
      if (arvalid && !arready && !rvalid) arready <= 1'b1;
      if (read_fire)             rvalid <= 1'b1;
      else if (rvalid && rready) rvalid <= 1'b0;
    end
  end

  // Status snapshot taken at address accept
  always_ff @(posedge clk) begin
    if (read_fire) begin
      rdata <= '0;
      rresp <= axil_pkg::RESP_OKAY;
      case (araddr)
        axil_pkg::REG_CTRL:   rdata[axil_pkg::CTRL_EN_BIT] <= enable;
        axil_pkg::REG_STATUS: rdata <= status_word;
        axil_pkg::REG_DATA:   rdata <= '0;  // Write only reads as zero
        default:              rresp <= axil_pkg::RESP_SLVERR;
      endcase
    end
  end

endmodule

/* i2s_tx_top.sv */
// ------------------------------------------------
// I2S transmitter top level with an AXI4-Lite slave
// Register block, frame FIFO, timing and serializer
// ------------------------------------------------
`timescale 1ns/1ps

module i2s_tx_top #(
  parameter int unsigned CLK_RATE     = 24_576_000,
  parameter int unsigned AUDIO_RATE   = 48_000,
  parameter bit          I2S_STANDARD = 1'b1,
  parameter int unsigned FIFO_DEPTH   = 16
) (
  input  logic                          clk,
  input  logic                          reset,
  // AXI4-Lite slave
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [axil_pkg::ADDR_W-1:0]   awaddr,
  input  logic                          wvalid,
  output logic                          wready,
  input  logic [axil_pkg::DATA_W-1:0]   wdata,
  input  logic [axil_pkg::DATA_W/8-1:0] wstrb,
  output logic                          bvalid,
  input  logic                          bready,
  output logic [1:0]                    bresp,
  input  logic                          arvalid,
  output logic                          arready,
  input  logic [axil_pkg::ADDR_W-1:0]   araddr,
  output logic                          rvalid,
  input  logic                          rready,
  output logic [axil_pkg::DATA_W-1:0]   rdata,
  output logic [1:0]                    rresp,
  // I2S pins
  output logic                          i2s_bclk,
  output logic                          i2s_lrclk,
  output logic                          i2s_sdata,
  output logic                          audio_clk
);

  logic                        enable;
  logic                        push;
  audio_cfg_pkg::frame_u       push_frame;
  audio_cfg_pkg::frame_u       head_frame;
  logic                        pop;
  logic [$clog2(FIFO_DEPTH):0] fifo_level;
  logic                        fifo_full;
  logic                        fifo_empty;
  logic                        underrun;

  i2s_timing_if timing_bus ();

  i2s_tx_ctrl #(.FIFO_DEPTH(FIFO_DEPTH)) i_ctrl (
    .clk, .reset,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .fifo_level, .fifo_full, .fifo_empty, .underrun,
    .push, .push_frame, .enable
  );

  audio_timing #(
    .CLK_RATE    (CLK_RATE),
    .AUDIO_RATE  (AUDIO_RATE),
    .I2S_STANDARD(I2S_STANDARD)
  ) i_timing (
    .clk, .reset, .enable,
    .timing   (timing_bus.source),
    .audio_clk
  );

  frame_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
    .clk, .reset, .push, .push_frame, .pop, .head_frame,
    .level (fifo_level),
    .full  (fifo_full),
    .empty (fifo_empty)
  );

  i2s_serializer i_serializer (
    .clk, .reset, .enable,
    .timing    (timing_bus.sink),
    .head_frame,
    .fifo_empty,
    .pop,
    .underrun,
    .sdata     (i2s_sdata)
  );

  // Pin clocks straight from the generator
  assign i2s_bclk  = timing_bus.bclk;
  assign i2s_lrclk = timing_bus.lrclk;

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and pass only if the testbench reports success
verilator --binary --timing --assert -j 0 --top-module tb_i2s_tx \
  -f i2s_tx.f -o tb_i2s_tx_sim \
  && ./obj_dir/tb_i2s_tx_sim | tee /dev/stderr | grep -qx "TB PASSED" \
  && echo "Simulation run: success" \
  || { echo "Simulation run: failure"; exit 1; }

/* tb_clock_gen.sv */
// ------------------------------------------------
// Testbench clock and reset source
// 20 ns clock, reset high for the first 4 cycles
// ------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS    = 20.0,
  parameter int  RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 reset = 1'b0;  // Release away from the edge
  end

endmodule

/* tb_i2s_tx.sv */
// ------------------------------------------------
// Testbench of the I2S transmitter: AXI4-Lite host tasks,
// an I2S receiver model and assertion based checks
// ------------------------------------------------
`timescale 1ns/1ps

module tb_i2s_tx;

  localparam int unsigned FIFO_DEPTH    = 16;
  localparam int          AXI_TIMEOUT   = 50;         // clk cycles per handshake
  localparam int          FRAME_TIMEOUT = 40 * 512;   // About 40 LRCLK periods
  localparam logic [31:0] CTRL_EN       = 32'd1 << axil_pkg::CTRL_EN_BIT;
  localparam logic [31:0] CTRL_CLR      = 32'd1 << axil_pkg::CTRL_CLR_BIT;
  localparam logic [axil_pkg::ADDR_W-1:0] REG_UNMAPPED = 4'hC;

  logic clk, reset;
  logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready, rvalid, rready;
  logic [axil_pkg::ADDR_W-1:0]   awaddr, araddr;
  logic [axil_pkg::DATA_W-1:0]   wdata, rdata;
  logic [axil_pkg::DATA_W/8-1:0] wstrb;
  logic [1:0] bresp, rresp;
  logic i2s_bclk, i2s_lrclk, i2s_sdata, audio_clk;

  // Bookkeeping
  int    errors, tests_run, tests_failed, test_errors_at;
  string cur_test = "startup";
  logic  en_req;                       // Set just before EN is written
  logic [31:0] lfsr_state;
  logic [31:0] expected_frames [$];    // Frames in write order

  // Receiver and timing monitor state
  logic bclk_q, lrclk_q, rx_active, rx_skip, timing_started;
  logic [31:0] rx_shift;
  int rx_bits, rx_count, lr_periods, bclk_rises, fs_count;

  tb_clock_gen i_clock_gen (.clk, .reset);

  i2s_tx_top #(.FIFO_DEPTH(FIFO_DEPTH), .I2S_STANDARD(1'b1)) i_i2s_tx_top (.*);

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);   // One step per bit
      word       = {word[30:0], lfsr_state[0]};
    end
    return word;
  endfunction

  // STATUS as the register map defines it
  function automatic logic [31:0] expected_status(input int unsigned level, input logic flag);
    logic [31:0] w;
    w = '0;
    w[axil_pkg::STATUS_LEVEL_LSB +: axil_pkg::STATUS_LEVEL_W] = 8'(level);
    w[axil_pkg::STATUS_FULL_BIT]     = (level == FIFO_DEPTH);
    w[axil_pkg::STATUS_EMPTY_BIT]    = (level == 0);
    w[axil_pkg::STATUS_UNDERRUN_BIT] = flag;
    return w;
  endfunction

  task automatic expect_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("Error: %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("Timeout in %s: %s", cur_test, reason);
    $display("TB FAILED");
    $finish;
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_errors_at = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_errors_at) begin
      $display("Test %-10s ok", cur_test);
    end else begin
      tests_failed++;
      $display("Test %-10s failed with %0d errors", cur_test, errors - test_errors_at);
    end
  endtask

  // ------------------------------------------------
  // AXI4-Lite host
  // ------------------------------------------------
  task automatic axi_write(input logic [axil_pkg::ADDR_W-1:0] addr,
                           input logic [31:0] data, output logic [1:0] resp);
    int cycles;
    @(posedge clk);
    #2;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    cycles  = 0;
    while (!(awready && wready)) begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > AXI_TIMEOUT) abort_run("write address and data never accepted");
    end
    @(posedge clk);  // AW and W taken here
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    cycles  = 0;
    while (!bvalid) begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > AXI_TIMEOUT) abort_run("write response never arrived");
    end
    @(posedge clk);  // Response waits one cycle for bready
    #2;
    bready = 1'b1;
    resp   = bresp;
    @(posedge clk);
    #2;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [axil_pkg::ADDR_W-1:0] addr,
                          output logic [31:0] data, output logic [1:0] resp);
    int cycles;
    @(posedge clk);
    #2;
    araddr  = addr;
    arvalid = 1'b1;
    cycles  = 0;
    while (!arready) begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > AXI_TIMEOUT) abort_run("read address never accepted");
    end
    @(posedge clk);
    #2;
    arvalid = 1'b0;
    cycles  = 0;
    while (!rvalid) begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > AXI_TIMEOUT) abort_run("read data never arrived");
    end
    @(posedge clk);  // Data waits one cycle for rready
    #2;
    rready = 1'b1;
    data   = rdata;
    resp   = rresp;
    @(posedge clk);
    #2;
    rready = 1'b0;
  endtask

  // Random frame into DATA, kept for the receiver if accepted
  task automatic write_frame(input logic [1:0] exp_resp);
    logic [31:0] frame;
    logic [1:0]  resp;
    frame = random_word();
    axi_write(axil_pkg::REG_DATA, frame, resp);
    expect_equal("DATA write resp", {30'd0, exp_resp}, {30'd0, resp});
    if (exp_resp == axil_pkg::RESP_OKAY) expected_frames.push_back(frame);
  endtask

  task automatic check_status(input int unsigned level, input logic flag);
    logic [31:0] rd;
    logic [1:0]  resp;
    axi_read(axil_pkg::REG_STATUS, rd, resp);
    expect_equal("STATUS read resp", {30'd0, axil_pkg::RESP_OKAY}, {30'd0, resp});
    expect_equal("STATUS", expected_status(level, flag), rd);
  endtask

  // Receiver word check, silence once the queue runs dry
  task automatic check_frame(input logic [31:0] got);
    logic [31:0] exp;
    exp = (expected_frames.size() > 0) ? expected_frames.pop_front() : 32'd0;
    expect_equal("left word", {16'h0000, exp[31:16]}, {16'h0000, got[31:16]});
    expect_equal("right word", {16'h0000, exp[15:0]}, {16'h0000, got[15:0]});
    rx_count++;
  endtask

  // ------------------------------------------------
  // I2S receiver and timing monitor, sampled on negedge
  // ------------------------------------------------
  always @(negedge clk) begin
    if (!reset) begin
      if (lrclk_q && !i2s_lrclk) begin  // Left word starts
        if (timing_started) begin
          expect_equal("bclk rises per lrclk period", 32'd32, bclk_rises);
          lr_periods++;
        end
        timing_started = 1'b1;
        bclk_rises     = 0;
        if (!rx_active) begin
          rx_active = 1'b1;
          rx_skip   = 1'b1;  // One bit delay of standard I2S
          rx_bits   = 0;
        end
      end
      if (timing_started && audio_clk) fs_count++;
      if (!bclk_q && i2s_bclk) begin
        if (timing_started) bclk_rises++;
        if (rx_active && rx_skip) begin
          rx_skip = 1'b0;
        end else if (rx_active) begin
          rx_shift = {rx_shift[30:0], i2s_sdata};  // MSB first
          rx_bits++;
          if (rx_bits == 32) begin
            check_frame(rx_shift);
            rx_bits = 0;
          end
        end
      end
    end
    bclk_q  = i2s_bclk;
    lrclk_q = i2s_lrclk;
  end

  // Pins quiet until EN is requested
  assert property (@(posedge clk) disable iff (reset)
    !en_req |-> (!i2s_bclk && !i2s_lrclk && !i2s_sdata))
    else begin
      errors++;
      $display("Error: I2S pins toggled while the transmitter was disabled");
    end

  // Responses held until taken
  assert property (@(posedge clk) disable iff (reset) (bvalid && !bready) |=> bvalid)
    else begin
      errors++;
      $display("Error: bvalid dropped before bready");
    end
  assert property (@(posedge clk) disable iff (reset) (rvalid && !rready) |=> rvalid)
    else begin
      errors++;
      $display("Error: rvalid dropped before rready");
    end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic [1:0]  resp;
    int          cycles;
    int          diff;
    logic        lr_prev;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    rready  = 1'b0;
    awaddr  = '0;
    araddr  = '0;
    wdata   = '0;
    wstrb   = '0;
    en_req  = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    lfsr_state = 32'hafce;
    {bclk_q, lrclk_q, rx_active, rx_skip, timing_started} = '0;
    rx_shift = '0;
    {rx_bits, rx_count, lr_periods, bclk_rises, fs_count} = '0;

    cycles = 0;
    while (reset !== 1'b0) begin
      @(posedge clk);
      cycles++;
      if (cycles > 20) abort_run("reset never released");
    end

    // Idle after reset
    start_test("reset_idle");
    repeat (64) @(posedge clk);  // Pin assertion watches this window
    check_status(0, 1'b0);
    finish_test();

    // DATA path, fill and error responses
    start_test("data_path");
    for (int i = 0; i < 5; i++) write_frame(axil_pkg::RESP_OKAY);
    check_status(5, 1'b0);
    for (int i = 5; i < FIFO_DEPTH; i++) write_frame(axil_pkg::RESP_OKAY);
    check_status(FIFO_DEPTH, 1'b0);
    write_frame(axil_pkg::RESP_SLVERR);  // Dropped on full
    check_status(FIFO_DEPTH, 1'b0);
    axi_write(REG_UNMAPPED, 32'h1234_5678, resp);
    expect_equal("unmapped write resp", {30'd0, axil_pkg::RESP_SLVERR}, {30'd0, resp});
    axi_read(REG_UNMAPPED, rd, resp);
    expect_equal("unmapped read resp", {30'd0, axil_pkg::RESP_SLVERR}, {30'd0, resp});
    finish_test();

    // Playback of the queued frames
    start_test("playback");
    en_req = 1'b1;
    axi_write(axil_pkg::REG_CTRL, CTRL_EN, resp);
    expect_equal("CTRL write resp", {30'd0, axil_pkg::RESP_OKAY}, {30'd0, resp});
    cycles = 0;
    while (rx_count < int'(FIFO_DEPTH)) begin
      @(negedge clk);
      cycles++;
      if (cycles > FRAME_TIMEOUT) abort_run("queued frames not all received");
    end
    finish_test();

    // Clock structure over many frames
    start_test("timing");
    cycles = 0;
    while (lr_periods < 24) begin
      @(negedge clk);
      cycles++;
      if (cycles > FRAME_TIMEOUT) abort_run("too few lrclk periods seen");
    end
    diff = fs_count - lr_periods;
    assert (diff >= -1 && diff <= 1) else begin
      errors++;
      $display("Error: %s audio_clk pulses expected %0d actual %0d", cur_test,
               lr_periods, fs_count);
    end
    finish_test();

    // Underrun flag and its clear
    start_test("underrun");
    expect_equal("silent frames seen", 32'd1, {31'd0, rx_count > int'(FIFO_DEPTH)});
    check_status(0, 1'b1);
    cycles  = 0;
    lr_prev = 1'b1;
    while (lr_prev !== 1'b0 || i2s_lrclk !== 1'b1) begin  // Right word start
      lr_prev = i2s_lrclk;
      @(negedge clk);
      cycles++;
      if (cycles > FRAME_TIMEOUT) abort_run("no lrclk rise before the clear");
    end
    axi_write(axil_pkg::REG_CTRL, CTRL_EN | CTRL_CLR, resp);
    expect_equal("CTRL write resp", {30'd0, axil_pkg::RESP_OKAY}, {30'd0, resp});
    check_status(0, 1'b0);
    axi_read(axil_pkg::REG_CTRL, rd, resp);
    expect_equal("CTRL readback", CTRL_EN, rd);
    finish_test();

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
